// File: verif/ex_stage_stimulus.txt
# func opa_sel opb_sel rs1_fwd rs2_fwd br_cond br_reg vld pc imm rs1 rs2 mem wb
# expected: alu_res vld take_br br_pc mem_din, all fields in hex
00 0 0 0 0 0 0 1 100 8 5 7 0 0 c 1 0 108 7
01 0 0 0 0 0 0 1 100 8 5 7 0 0 fffffffe 1 0 108 7
02 0 0 0 0 0 0 1 100 8 f0f0f0f0 0ff00ff0 0 0 ff00ff00 1 0 108 0ff00ff0
03 0 0 0 0 0 0 1 100 8 f0f0f0f0 0ff00ff0 0 0 fff0fff0 1 0 108 0ff00ff0
04 0 0 0 0 0 0 1 100 8 f0f0f0f0 0ff00ff0 0 0 00f000f0 1 0 108 0ff00ff0
05 0 0 0 0 0 0 1 100 8 1 24 0 0 10 1 0 108 24
06 0 0 0 0 0 0 1 100 8 80000000 4 0 0 08000000 1 0 108 4
07 0 0 0 0 0 0 1 100 8 80000000 4 0 0 f8000000 1 0 108 4
08 0 0 0 0 0 0 1 100 8 ffffffff 1 0 0 1 1 0 108 1
09 0 0 0 0 0 0 1 100 8 ffffffff 1 0 0 0 1 0 108 1
00 0 0 1 2 0 0 1 100 8 1 2 10 20 30 1 0 108 20
00 0 0 2 1 0 0 1 100 8 1 2 100 200 300 1 0 108 100
00 2 1 0 0 0 0 1 100 12345000 1 2 0 0 12345000 1 0 12345100 2
00 1 2 0 0 7 0 1 100 8 1 2 0 0 104 1 1 108 2
0a 0 0 0 0 0 0 1 100 8 fffffffe 3 0 0 fffffffa 1 0 108 3
0b 0 0 0 0 0 0 1 100 8 fffffffe 3 0 0 ffffffff 1 0 108 3
0c 0 0 0 0 0 0 1 100 8 fffffffe ffffffff 0 0 fffffffe 1 0 108 ffffffff
0d 0 0 0 0 0 0 1 100 8 fffffffe ffffffff 0 0 fffffffd 1 0 108 ffffffff
0e 0 0 0 0 0 0 1 100 8 fffffff9 2 0 0 fffffffd 1 0 108 2
10 0 0 0 0 0 0 1 100 8 fffffff9 2 0 0 ffffffff 1 0 108 2
0f 0 0 0 0 0 0 1 100 8 fffffff9 2 0 0 7ffffffc 1 0 108 2
11 0 0 0 0 0 0 1 100 8 fffffff9 2 0 0 1 1 0 108 2
0e 0 0 0 0 0 0 1 100 8 14 0 0 0 ffffffff 1 0 108 0
10 0 0 0 0 0 0 1 100 8 fffffff9 0 0 0 fffffff9 1 0 108 0
11 0 0 0 0 0 0 1 100 8 14 0 0 0 14 1 0 108 0
0e 0 0 0 0 0 0 1 100 8 80000000 ffffffff 0 0 80000000 1 0 108 ffffffff
10 0 0 0 0 0 0 1 100 8 80000000 ffffffff 0 0 0 1 0 108 ffffffff
01 0 0 0 0 1 0 1 100 20 5 5 0 0 0 1 1 120 5
01 0 0 0 0 1 0 1 100 20 5 6 0 0 ffffffff 1 0 120 6
01 0 0 0 0 2 0 1 100 20 5 6 0 0 ffffffff 1 1 120 6
01 0 0 0 0 2 0 1 100 20 5 5 0 0 0 1 0 120 5
08 0 0 0 0 3 0 1 100 20 ffffffff 1 0 0 1 1 1 120 1
08 0 0 0 0 3 0 1 100 20 1 ffffffff 0 0 0 1 0 120 ffffffff
08 0 0 0 0 4 0 1 100 20 1 ffffffff 0 0 0 1 1 120 ffffffff
08 0 0 0 0 4 0 1 100 20 ffffffff 1 0 0 1 1 0 120 1
09 0 0 0 0 5 0 1 100 20 1 ffffffff 0 0 1 1 1 120 ffffffff
09 0 0 0 0 5 0 1 100 20 ffffffff 1 0 0 0 1 0 120 1
09 0 0 0 0 6 0 1 100 20 ffffffff 1 0 0 0 1 1 120 1
09 0 0 0 0 6 0 1 100 20 1 ffffffff 0 0 1 1 0 120 ffffffff
00 1 2 0 0 7 1 1 100 10 1001 2 0 0 104 1 1 1010 2
00 1 2 0 0 7 0 0 100 20 1 2 0 0 104 0 0 120 2
12 0 0 0 0 7 0 1 100 8 1 2 0 0 0 0 0 108 2
1f 0 0 0 0 0 0 1 100 8 1 2 0 0 0 0 0 108 2

// File: ex_stage.f
common/ex_pkg.sv
verilog/int_alu.sv
verilog/multiplier.sv
divider/divider.sv
verilog/branch_unit.sv
verilog/ex_ctrl.sv
verilog/ex_stage.sv
verif/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and scan the log

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ex_stage_tb -f ex_stage.f -o ex_stage_sim \
	&& ./obj_dir/ex_stage_sim > sim.log 2>&1 \
	|| echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && echo "Simulation failed" && exit 1
echo "Simulation passed"
exit 0

// File: verif/ex_stage_tb.sv
module ex_stage_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import ex_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 4;
	localparam int CYCLES_PER_VECTOR = 40;
	localparam int DIV_CYCLES = 33;
	localparam string STIMULUS_FILE = "verif/ex_stage_stimulus.txt";

	typedef struct packed {
		ex_req_t     req;
		ex_fwd_t     src;
		logic [31:0] alu_res;
		logic        vld;
		logic        take_br;
		logic [31:0] br_pc;
		logic [31:0] mem_din;
	} vector_t;

	logic     clk = 1'b0;
	logic     rst;
	ex_req_t  req;
	ex_fwd_t  src;
	ex_resp_t resp;

	vector_t vectors[$];
	bit      loaded = 1'b0;
	int      errors = 0;
	int      pass_count = 0;
	int      fail_count = 0;

	ex_stage ex_stage_i (
		.clk  (clk),
		.rst  (rst),
		.req  (req),
		.src  (src),
		.resp (resp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// A valid divide or remainder stalls for the full divider run
	function automatic int expected_busy_cycles(input ex_req_t r);
		if (r.vld && (r.func == ALU_DIV || r.func == ALU_DIVU
			|| r.func == ALU_REM || r.func == ALU_REMU))
			return DIV_CYCLES;
		return 0;
	endfunction

	// Columns: request fields, four source words, then the expected outputs
	task automatic load_vectors(output bit ok);
		int          fd;
		int          count;
		string       line;
		logic [31:0] v [19];
		vector_t     vec;
		bit          bad_line;
		ok = 1'b0;
		bad_line = 1'b0;
		fd = $fopen(STIMULUS_FILE, "r");
		if (fd == 0) begin
			$display("Could not open stimulus file %s", STIMULUS_FILE);
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			count = $sscanf(line,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
				v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
			if (count != 19) begin
				if (count > 0) begin
					$display("Malformed stimulus line: %s", line);
					bad_line = 1'b1;
				end
				continue;
			end
			vec.req.func    = alu_func_e'(v[0][4:0]);
			vec.req.opa_sel = opa_sel_e'(v[1][1:0]);
			vec.req.opb_sel = opb_sel_e'(v[2][1:0]);
			vec.req.rs1_fwd = fwd_sel_e'(v[3][1:0]);
			vec.req.rs2_fwd = fwd_sel_e'(v[4][1:0]);
			vec.req.br_cond = br_cond_e'(v[5][2:0]);
			vec.req.br_reg  = v[6][0];
			vec.req.vld     = v[7][0];
			vec.req.pc      = v[8];
			vec.req.imm     = v[9];
			vec.src.rs1_data = v[10];
			vec.src.rs2_data = v[11];
			vec.src.mem_data = v[12];
			vec.src.wb_data  = v[13];
			vec.alu_res = v[14];
			vec.vld     = v[15][0];
			vec.take_br = v[16][0];
			vec.br_pc   = v[17];
			vec.mem_din = v[18];
			vectors.push_back(vec);
		end
		$fclose(fd);
		ok = (vectors.size() > 0) && !bad_line;
	endtask

	initial begin
		bit load_ok;
		int errors_before;
		int busy_cycles;
		rst = 1'b1;
		req = '0;
		src = '0;
		load_vectors(load_ok);
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		foreach (vectors[i]) begin
			@(posedge clk);
			req <= vectors[i].req;
			src <= vectors[i].src;
			// A divide holds busy for 33 cycles
			busy_cycles = 0;
			@(negedge clk);
			while (resp.busy) begin
				busy_cycles++;
				@(negedge clk);
			end
			errors_before = errors;
			check_value("resp.busy cycles", busy_cycles,
				expected_busy_cycles(vectors[i].req));
			if (vectors[i].vld)
				check_value("resp.alu_res", resp.alu_res, vectors[i].alu_res);
			check_value("resp.vld", 32'(resp.vld), 32'(vectors[i].vld));
			check_value("resp.take_br", 32'(resp.take_br), 32'(vectors[i].take_br));
			check_value("resp.br_pc", resp.br_pc, vectors[i].br_pc);
			check_value("resp.mem_din", resp.mem_din, vectors[i].mem_din);
			if (errors == errors_before) begin
				pass_count++;
				$display("vector %0d passed", i);
			end else begin
				fail_count++;
				$display("vector %0d failed", i);
			end
		end
		$display("%0d vectors passed, %0d vectors failed", pass_count, fail_count);
		if (load_ok && fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			if (!load_ok)
				$display("Stimulus file missing, empty or malformed");
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		#(CLK_PERIOD * (RESET_CYCLES + vectors.size() * CYCLES_PER_VECTOR));
		$display("Simulation timed out waiting for busy to drop");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: verilog/ex_stage.sv
module ex_stage (
	input  logic             clk,
	input  logic             rst,
	input  ex_pkg::ex_req_t  req,
	input  ex_pkg::ex_fwd_t  src,
	output ex_pkg::ex_resp_t resp
);
	import ex_pkg::*;

	logic [31:0] opa;
	logic [31:0] opb;
	logic [31:0] rs1_val;
	logic [31:0] alu_out;
	logic [63:0] mul_out;
	logic [31:0] quotient;
	logic [31:0] remainder;
	logic        div_busy;
	div_req_t    div_req;
	logic [31:0] alu_res;
	logic [31:0] mem_din;
	logic        vld;
	logic        busy;
	logic [31:0] br_pc;
	logic        take_br;

	ex_ctrl ex_ctrl_i (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.src       (src),
		.alu_out   (alu_out),
		.mul_out   (mul_out),
		.quotient  (quotient),
		.remainder (remainder),
		.div_busy  (div_busy),
		.opa       (opa),
		.opb       (opb),
		.rs1_val   (rs1_val),
		.div_req   (div_req),
		.alu_res   (alu_res),
		.mem_din   (mem_din),
		.vld       (vld),
		.busy      (busy)
	);

	int_alu int_alu_i (
		.opa    (opa),
		.opb    (opb),
		.func   (req.func),
		.result (alu_out)
	);

	multiplier multiplier_i (
		.opa     (opa),
		.opb     (opb),
		.func    (req.func),
		.product (mul_out)
	);

	divider divider_i (
		.clk       (clk),
		.rst       (rst),
		.req       (div_req),
		.quotient  (quotient),
		.remainder (remainder),
		.busy      (div_busy)
	);

	branch_unit branch_unit_i (
		.alu_res (alu_res),
		.rs1_val (rs1_val),
		.pc      (req.pc),
		.imm     (req.imm),
		.cond    (req.br_cond),
		.br_reg  (req.br_reg),
		.vld     (vld),
		.br_pc   (br_pc),
		.take_br (take_br)
	);

	assign resp = '{alu_res: alu_res, mem_din: mem_din, br_pc: br_pc,
		take_br: take_br, vld: vld, busy: busy};

endmodule

// File: verilog/ex_ctrl.sv
module ex_ctrl (
	input  logic             clk,
	input  logic             rst,
	input  ex_pkg::ex_req_t  req,
	input  ex_pkg::ex_fwd_t  src,
	input  logic [31:0]      alu_out,
	input  logic [63:0]      mul_out,
	input  logic [31:0]      quotient,
	input  logic [31:0]      remainder,
	input  logic             div_busy,
	output logic [31:0]      opa,
	output logic [31:0]      opb,
	output logic [31:0]      rs1_val,
	output ex_pkg::div_req_t div_req,
	output logic [31:0]      alu_res,
	output logic [31:0]      mem_din,
	output logic             vld,
	output logic             busy
);
	import ex_pkg::*;

	logic [31:0] rs2_val;
	logic [31:0] prev_opa;
	logic [31:0] prev_opb;
	alu_func_e   prev_func;
	logic        prev_vld;
	logic        new_input;
	logic        is_div;
	logic        start;

	// Forwarding from later stages
	always_comb begin
		case (req.rs1_fwd)
			FWD_MEM: rs1_val = src.mem_data;
			FWD_WB:  rs1_val = src.wb_data;
			default: rs1_val = src.rs1_data;
		endcase
		case (req.rs2_fwd)
			FWD_MEM: rs2_val = src.mem_data;
			FWD_WB:  rs2_val = src.wb_data;
			default: rs2_val = src.rs2_data;
		endcase
	end

	always_comb begin
		case (req.opa_sel)
			OPA_RS:  opa = rs1_val;
			OPA_PC:  opa = req.pc;
			default: opa = 32'h0;
		endcase
		case (req.opb_sel)
			OPB_RS:  opb = rs2_val;
			OPB_IMM: opb = req.imm;
			default: opb = 32'h4;
		endcase
	end

	assign mem_din = rs2_val;

	always_ff @(posedge clk) begin
		prev_opa <= opa;
		prev_opb <= opb;
		if (rst) begin
			prev_func <= ALU_ADD;
			prev_vld  <= 1'b0;
		end else begin
			prev_func <= req.func;
			prev_vld  <= req.vld;
		end
	end

	// Restart the divider only on a changed or freshly valid request
	assign new_input = (prev_opa != opa) || (prev_opb != opb) || (prev_func != req.func)
		|| (req.vld && !prev_vld);

	assign is_div = (req.func == ALU_DIV) || (req.func == ALU_DIVU)
		|| (req.func == ALU_REM) || (req.func == ALU_REMU);
	assign start = is_div && req.vld && new_input && !div_busy;

	always_comb begin
		div_req.dividend  = opa;
		div_req.divisor   = opb;
		div_req.is_signed = (req.func == ALU_DIV) || (req.func == ALU_REM);
		div_req.start     = start;
	end

	always_comb begin
		alu_res = 32'h0;
		vld     = req.vld;
		case (req.func)
			ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
			ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU: alu_res = alu_out;
			ALU_MUL:                                      alu_res = mul_out[31:0];
			ALU_MULH, ALU_MULHSU, ALU_MULHU:              alu_res = mul_out[63:32];
			ALU_DIV, ALU_DIVU:                            alu_res = quotient;
			ALU_REM, ALU_REMU:                            alu_res = remainder;
			default:                                      vld = 1'b0;
		endcase
	end

	// Hold earlier stages from the start cycle onward
	assign busy = div_busy || start;

	// The divider must accept every start
	assert property (@(posedge clk) disable iff (rst)
		div_req.start |=> div_busy);

endmodule

// File: verilog/branch_unit.sv
module branch_unit (
	input  logic [31:0]      alu_res,
	input  logic [31:0]      rs1_val,
	input  logic [31:0]      pc,
	input  logic [31:0]      imm,
	input  ex_pkg::br_cond_e cond,
	input  logic             br_reg,
	input  logic             vld,
	output logic [31:0]      br_pc,
	output logic             take_br
);
	import ex_pkg::*;

	logic is_zero;

	assign is_zero = (alu_res == 32'h0);

	// ALU runs SUB, SLT or SLTU for the compare
	always_comb begin
		case (cond)
			BR_BEQ:           take_br = is_zero;
			BR_BNE:           take_br = !is_zero;
			BR_BLT, BR_BLTU:  take_br = alu_res[0];
			BR_BGE, BR_BGEU:  take_br = !alu_res[0];
			BR_UNC:           take_br = 1'b1;
			default:          take_br = 1'b0;
		endcase
		if (!vld)
			take_br = 1'b0;
	end

	// JALR target drops bit 0
	assign br_pc = br_reg ? ((rs1_val + imm) & ~32'h1) : (pc + imm);

endmodule

// File: divider/divider.sv
module divider (
	input  logic             clk,
	input  logic             rst,
	input  ex_pkg::div_req_t req,
	output logic [31:0]      quotient,
	output logic [31:0]      remainder,
	output logic             busy
);
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FIX
	} state_e;

	state_e      state;
	logic [4:0]  step_cnt;
	logic [31:0] quo;
	logic [31:0] rem;
	logic [31:0] divisor_mag;
	logic [31:0] dividend_raw;
	logic        neg_q;
	logic        neg_r;
	logic        div_zero;
	logic [31:0] a_mag;
	logic [31:0] b_mag;
	logic [63:0] first_step;

	// One restoring step, returns {remainder, quotient/dividend shift register}
	function automatic logic [63:0] div_step(input logic [31:0] r, input logic [31:0] q,
		input logic [31:0] d);
		logic [32:0] shifted;
		logic [32:0] diff;
		shifted = {r, q[31]};
		diff = shifted - {1'b0, d};
		if (diff[32])
			return {shifted[31:0], q[30:0], 1'b0};
		else
			return {diff[31:0], q[30:0], 1'b1};
	endfunction

	assign a_mag = (req.is_signed && req.dividend[31]) ? -req.dividend : req.dividend;
	assign b_mag = (req.is_signed && req.divisor[31]) ? -req.divisor : req.divisor;

	// First step is taken on the start edge
	assign first_step = div_step(32'h0, a_mag, b_mag);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			step_cnt <= 5'd0;
		end else begin
			case (state)
				IDLE: begin
					if (req.start) begin
						state    <= RUN;
						step_cnt <= 5'd0;
					end
				end
				RUN: begin
					step_cnt <= step_cnt + 5'd1;
					if (step_cnt == 5'd30)
						state <= FIX;
				end
				FIX:     state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (req.start) begin
					{rem, quo}   <= first_step;
					divisor_mag  <= b_mag;
					dividend_raw <= req.dividend;
					div_zero     <= (req.divisor == 32'h0);
					neg_q        <= req.is_signed && (req.dividend[31] ^ req.divisor[31]);
					neg_r        <= req.is_signed && req.dividend[31];
				end
			end
			RUN: {rem, quo} <= div_step(rem, quo, divisor_mag);
			FIX: begin
				if (div_zero) begin
					quo <= 32'hffff_ffff;
					rem <= dividend_raw;
				end else begin
					// Overflow case wraps back to the dividend here
					if (neg_q)
						quo <= -quo;
					if (neg_r)
						rem <= -rem;
				end
			end
			default: ;
		endcase
	end

	assign quotient  = quo;
	assign remainder = rem;
	assign busy      = (state != IDLE);

	assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> ##32 !busy);

endmodule

// File: verilog/multiplier.sv
module multiplier (
	input  logic [31:0]       opa,
	input  logic [31:0]       opb,
	input  ex_pkg::alu_func_e func,
	output logic [63:0]       product
);
	import ex_pkg::*;

	logic               a_signed;
	logic               b_signed;
	logic signed [32:0] a_ext;
	logic signed [32:0] b_ext;

	// MUL only needs the low word, so its extension does not matter
	assign a_signed = (func == ALU_MULH) || (func == ALU_MULHSU);
	assign b_signed = (func == ALU_MULH);

	assign a_ext = {a_signed & opa[31], opa};
	assign b_ext = {b_signed & opb[31], opb};

	// Low 64 bits of the 33x33 signed product
	assign product = 64'(a_ext) * 64'(b_ext);

endmodule

// File: verilog/int_alu.sv
module int_alu (
	input  logic [31:0]       opa,
	input  logic [31:0]       opb,
	input  ex_pkg::alu_func_e func,
	output logic [31:0]       result
);
	import ex_pkg::*;

	logic [4:0] shamt;

	assign shamt = opb[4:0];

	always_comb begin
		case (func)
			ALU_ADD: begin
				result = opa + opb;
			end
			ALU_SUB: begin
				result = opa - opb;
			end
			ALU_XOR: begin
				result = opa ^ opb;
			end
			ALU_OR: begin
				result = opa | opb;
			end
			ALU_AND: begin
				result = opa & opb;
			end
			ALU_SLL: begin
				result = opa << shamt;
			end
			ALU_SRL: begin
				result = opa >> shamt;
			end
			ALU_SRA: begin
				result = $unsigned($signed(opa) >>> shamt);
			end
			ALU_SLT: begin
				result = {31'h0, $signed(opa) < $signed(opb)};
			end
			ALU_SLTU: begin
				result = {31'h0, opa < opb};
			end
			// Multiply and divide results come from their own units
			default: begin
				result = 32'h0;
			end
		endcase
	end

endmodule

// File: common/ex_pkg.sv
package ex_pkg;

	// Execute operation codes, other encodings are unsupported
	typedef enum logic [4:0] {
		ALU_ADD    = 5'd0,
		ALU_SUB    = 5'd1,
		ALU_XOR    = 5'd2,
		ALU_OR     = 5'd3,
		ALU_AND    = 5'd4,
		ALU_SLL    = 5'd5,
		ALU_SRL    = 5'd6,
		ALU_SRA    = 5'd7,
		ALU_SLT    = 5'd8,
		ALU_SLTU   = 5'd9,
		ALU_MUL    = 5'd10,
		ALU_MULH   = 5'd11,
		ALU_MULHSU = 5'd12,
		ALU_MULHU  = 5'd13,
		ALU_DIV    = 5'd14,
		ALU_DIVU   = 5'd15,
		ALU_REM    = 5'd16,
		ALU_REMU   = 5'd17
	} alu_func_e;

	typedef enum logic [1:0] {
		FWD_RF  = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_e;

	typedef enum logic [1:0] {
		OPA_RS   = 2'd0,
		OPA_PC   = 2'd1,
		OPA_ZERO = 2'd2
	} opa_sel_e;

	typedef enum logic [1:0] {
		OPB_RS   = 2'd0,
		OPB_IMM  = 2'd1,
		OPB_FOUR = 2'd2
	} opb_sel_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BGE  = 3'd4,
		BR_BLTU = 3'd5,
		BR_BGEU = 3'd6,
		BR_UNC  = 3'd7
	} br_cond_e;

	// ID/EX register contents
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] imm;
		alu_func_e   func;
		fwd_sel_e    rs1_fwd;
		fwd_sel_e    rs2_fwd;
		opa_sel_e    opa_sel;
		opb_sel_e    opb_sel;
		br_cond_e    br_cond;
		logic        br_reg;
		logic        vld;
	} ex_req_t;

	typedef struct packed {
		logic [31:0] rs1_data;
		logic [31:0] rs2_data;
		logic [31:0] mem_data;
		logic [31:0] wb_data;
	} ex_fwd_t;

	typedef struct packed {
		logic [31:0] alu_res;
		logic [31:0] mem_din;
		logic [31:0] br_pc;
		logic        take_br;
		logic        vld;
		logic        busy;
	} ex_resp_t;

	typedef struct packed {
		logic [31:0] dividend;
		logic [31:0] divisor;
		logic        is_signed;
		logic        start;
	} div_req_t;

endpackage
